// ==== systolic_pkg.sv ====
package systolic_pkg;

  // element width of A, B and C
  localparam int data_width = 16;

  // array dimension, drain timing is built around it
  localparam int array_size = 4;

  // counter value where done goes high
  localparam int done_count = 4 * array_size + 2;

  // counter value where row 0 is captured
  // later rows follow one count apart
  localparam int latch_base = 11;

  // one matrix element
  typedef logic [data_width-1:0] elem_t;

  // running product sum, twice the element width
  typedef logic [2*data_width-1:0] acc_t;

  // four elements side by side, lane 0 in the low bits
  typedef logic [array_size*data_width-1:0] lane_vec_t;

  // cycle counter of the sequencer
  typedef logic [7:0] count_t;

  // sequencer FSM
  typedef enum logic [1:0] {
    seq_idle,
    seq_run,
    seq_done
  } seq_state_t;

endpackage

// ==== mm_ctrl_if.sv ====
interface mm_ctrl_if;

  // start low or reset
  // zeroes skew registers and accumulators
  logic clear;

  // first counted cycle
  // empties the skew triangle
  logic skew_clear;

  // capture strobe per result row
  // at most one set
  logic [systolic_pkg::array_size-1:0] row_latch;

  // sequencer cycle count
  systolic_pkg::count_t count;

  modport sequencer (
    output clear,
    output skew_clear,
    output row_latch,
    output count
  );

  modport skew (
    input clear,
    input skew_clear
  );

  modport array (
    input clear
  );

  // the drain acts on row_latch alone
  modport drain (
    input row_latch,
    input count
  );

endinterface

// ==== processing_element.sv ====
module processing_element (
  input  logic                clk,
  input  logic                reset,
  input  logic                clear,
  input  systolic_pkg::elem_t in_a,
  input  systolic_pkg::elem_t in_b,
  output systolic_pkg::elem_t out_a,
  output systolic_pkg::elem_t out_b,
  output systolic_pkg::elem_t out_c
);

  systolic_pkg::acc_t                 acc;
  systolic_pkg::acc_t                 product;
  logic [$bits(systolic_pkg::acc_t):0] sum_ext;

  // full 32 bit product
  assign product = in_a * in_b;

  // one extra bit to catch a carry out of the accumulator
  assign sum_ext = {1'b0, acc} + {1'b0, product};

  // saturating accumulate
  // a wrapped sum would hide an overflow from out_c
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      acc <= '0;
    end else if (sum_ext[$bits(systolic_pkg::acc_t)]) begin
      acc <= '1;
    end else begin
      acc <= sum_ext[$bits(systolic_pkg::acc_t)-1:0];
    end
  end

  // operands move one cell per cycle
  // A to the right, B downward
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      out_a <= '0;
      out_b <= '0;
    end else begin
      out_a <= in_a;
      out_b <= in_b;
    end
  end

  // clamp to all ones when anything sits in the high half
  assign out_c = (|acc[2*systolic_pkg::data_width-1:systolic_pkg::data_width]) ?
                 '1 : acc[systolic_pkg::data_width-1:0];

endmodule

// ==== pe_array.sv ====
module pe_array (
  input  logic                                                clk,
  input  logic                                                reset,
  input  systolic_pkg::lane_vec_t                             a_skewed,
  input  systolic_pkg::lane_vec_t                             b_skewed,
  output systolic_pkg::lane_vec_t [systolic_pkg::array_size-1:0] results,
  mm_ctrl_if.array                                            ctrl
);

  // a_link[r][c] feeds cell (r, c), last column spills out east
  wire systolic_pkg::elem_t a_link [systolic_pkg::array_size][systolic_pkg::array_size+1];

  // b_link[r][c] feeds cell (r, c), last row spills out south
  wire systolic_pkg::elem_t b_link [systolic_pkg::array_size+1][systolic_pkg::array_size];

  // saturated sum of every cell
  wire systolic_pkg::elem_t c_cell [systolic_pkg::array_size][systolic_pkg::array_size];

  for (genvar r = 0; r < systolic_pkg::array_size; r++) begin : g_row
    // A lane r enters the west edge of row r
    assign a_link[r][0] = a_skewed[r*systolic_pkg::data_width +: systolic_pkg::data_width];
    // B lane r enters the north edge of column r
    assign b_link[0][r] = b_skewed[r*systolic_pkg::data_width +: systolic_pkg::data_width];

    for (genvar c = 0; c < systolic_pkg::array_size; c++) begin : g_col
      processing_element pe_i (
        .clk   (clk),
        .reset (reset),
        .clear (ctrl.clear),
        .in_a  (a_link[r][c]),
        .in_b  (b_link[r][c]),
        .out_a (a_link[r][c+1]),
        .out_b (b_link[r+1][c]),
        .out_c (c_cell[r][c])
      );
    end
  end

  // pack each result row, column 0 in lane 0
  always_comb begin
    for (int r = 0; r < systolic_pkg::array_size; r++) begin
      for (int c = 0; c < systolic_pkg::array_size; c++) begin
        results[r][c*systolic_pkg::data_width +: systolic_pkg::data_width] = c_cell[r][c];
      end
    end
  end

endmodule

// ==== operand_skew.sv ====
module operand_skew (
  input  logic                    clk,
  input  logic                    reset,
  input  systolic_pkg::lane_vec_t slice,
  output systolic_pkg::lane_vec_t skewed,
  mm_ctrl_if.skew                 ctrl
);

  // lane k needs k register stages
  for (genvar k = 0; k < systolic_pkg::array_size; k++) begin : g_lane
    if (k == 0) begin : g_direct
      // lane 0 enters the array undelayed
      assign skewed[0 +: systolic_pkg::data_width] = slice[0 +: systolic_pkg::data_width];
    end else begin : g_delay
      systolic_pkg::elem_t stage [k];

      always_ff @(posedge clk) begin
        if (reset || ctrl.clear || ctrl.skew_clear) begin
          for (int s = 0; s < k; s++) begin
            stage[s] <= '0;
          end
        end else begin
          stage[0] <= slice[k*systolic_pkg::data_width +: systolic_pkg::data_width];
          // shift toward the array edge
          for (int s = 1; s < k; s++) begin
            stage[s] <= stage[s-1];
          end
        end
      end

      assign skewed[k*systolic_pkg::data_width +: systolic_pkg::data_width] = stage[k-1];
    end
  end

  // delayed lanes start empty on the first run cycle
  // lane 0 has no register and follows the memory
  assert property (@(posedge clk) disable iff (reset)
    ctrl.skew_clear |=>
      skewed[$bits(systolic_pkg::lane_vec_t)-1:systolic_pkg::data_width] == '0);

endmodule

// ==== result_drain.sv ====
module result_drain (
  input  logic                                                clk,
  input  logic                                                reset,
  input  systolic_pkg::lane_vec_t [systolic_pkg::array_size-1:0] results,
  output systolic_pkg::lane_vec_t                             c_data,
  mm_ctrl_if.drain                                            ctrl
);

  // one shift register per result row
  systolic_pkg::lane_vec_t [systolic_pkg::array_size-1:0] shift_q;

  // load on the row strobe, otherwise move one element toward lane output
  always_ff @(posedge clk) begin
    for (int r = 0; r < systolic_pkg::array_size; r++) begin
      if (reset) begin
        shift_q[r] <= '0;
      end else if (ctrl.row_latch[r]) begin
        shift_q[r] <= results[r];
      end else begin
        // zeros fill in behind the last element
        shift_q[r] <= shift_q[r] >> systolic_pkg::data_width;
      end
    end
  end

  // lane r shows the head of row r
  always_comb begin
    for (int r = 0; r < systolic_pkg::array_size; r++) begin
      c_data[r*systolic_pkg::data_width +: systolic_pkg::data_width] =
        shift_q[r][systolic_pkg::data_width-1:0];
    end
  end

  // rows never capture together
  assert property (@(posedge clk) disable iff (reset)
    $onehot0(ctrl.row_latch));

endmodule

// ==== mm_sequencer.sv ====
module mm_sequencer #(
  parameter int addr_width = 7
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  output logic                  done,
  output logic [addr_width-1:0] a_addr,
  output logic [addr_width-1:0] b_addr,
  mm_ctrl_if.sequencer          ctrl
);

  systolic_pkg::seq_state_t state;
  systolic_pkg::count_t     count;
  logic [addr_width-1:0]    op_addr;
  logic                     at_done_count;
  logic                     addr_step;

  assign at_done_count = (count == systolic_pkg::count_t'(systolic_pkg::done_count));

  // one slice per cycle during the first array_size counts
  assign addr_step = (state == systolic_pkg::seq_run) &&
                     (count < systolic_pkg::count_t'(systolic_pkg::array_size));

  // start low drops the block back to idle from any state
  always_ff @(posedge clk) begin
    if (reset || !start) begin
      state <= systolic_pkg::seq_idle;
    end else begin
      case (state)
        systolic_pkg::seq_idle: state <= systolic_pkg::seq_run;
        systolic_pkg::seq_run: begin
          if (at_done_count) begin
            state <= systolic_pkg::seq_done;
          end
        end
        default: state <= systolic_pkg::seq_done;
      endcase
    end
  end

  // counts only in run, parks at done_count
  always_ff @(posedge clk) begin
    if (reset || !start) begin
      count <= '0;
    end else if (state == systolic_pkg::seq_run && !at_done_count) begin
      count <= count + 1'b1;
    end
  end

  // ack side of the four-phase handshake
  always_ff @(posedge clk) begin
    if (reset || !start) begin
      done <= 1'b0;
    end else if (state == systolic_pkg::seq_run && at_done_count) begin
      done <= 1'b1;
    end
  end

  // parked at all ones, wraps to 0 on the first step
  always_ff @(posedge clk) begin
    if (reset || !start) begin
      op_addr <= '1;
    end else if (addr_step) begin
      op_addr <= op_addr + 1'b1;
    end else begin
      op_addr <= '1;
    end
  end

  // no tiling offset, so A and B walk the same addresses
  assign a_addr = op_addr;
  assign b_addr = op_addr;

  assign ctrl.clear      = reset || !start;
  assign ctrl.skew_clear = (state == systolic_pkg::seq_run) && (count == '0);
  assign ctrl.count      = count;

  // row r captured at latch_base + r
  always_comb begin
    for (int r = 0; r < systolic_pkg::array_size; r++) begin
      ctrl.row_latch[r] = (state == systolic_pkg::seq_run) &&
                          (count == systolic_pkg::count_t'(systolic_pkg::latch_base + r));
    end
  end

  // done may lag start by one edge only
  assert property (@(posedge clk) disable iff (reset)
    (!start && !$past(start)) |-> !done);

endmodule

// ==== matmul_top.sv ====
module matmul_top #(
  parameter int addr_width = 7
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start,
  output logic                    done,
  output logic [addr_width-1:0]   a_addr,
  output logic [addr_width-1:0]   b_addr,
  input  systolic_pkg::lane_vec_t a_data,
  input  systolic_pkg::lane_vec_t b_data,
  output systolic_pkg::lane_vec_t c_data
);

  // control fan-out from the sequencer
  mm_ctrl_if ctrl_if ();

  // wavefront into the array edges
  systolic_pkg::lane_vec_t a_skewed;
  systolic_pkg::lane_vec_t b_skewed;

  // saturated rows of C
  systolic_pkg::lane_vec_t [systolic_pkg::array_size-1:0] results;

  mm_sequencer #(
    .addr_width (addr_width)
  ) sequencer_i (
    .clk    (clk),
    .reset  (reset),
    .start  (start),
    .done   (done),
    .a_addr (a_addr),
    .b_addr (b_addr),
    .ctrl   (ctrl_if.sequencer)
  );

  // A slice holds a column of A, one lane per row
  operand_skew a_skew_i (
    .clk    (clk),
    .reset  (reset),
    .slice  (a_data),
    .skewed (a_skewed),
    .ctrl   (ctrl_if.skew)
  );

  // B slice holds a row of B, one lane per column
  operand_skew b_skew_i (
    .clk    (clk),
    .reset  (reset),
    .slice  (b_data),
    .skewed (b_skewed),
    .ctrl   (ctrl_if.skew)
  );

  pe_array array_i (
    .clk      (clk),
    .reset    (reset),
    .a_skewed (a_skewed),
    .b_skewed (b_skewed),
    .results  (results),
    .ctrl     (ctrl_if.array)
  );

  result_drain drain_i (
    .clk     (clk),
    .reset   (reset),
    .results (results),
    .c_data  (c_data),
    .ctrl    (ctrl_if.drain)
  );

endmodule

// ==== tb_operand_mem.sv ====
module tb_operand_mem #(
  parameter int addr_width = 7
) (
  input  logic                    clk,
  input  logic                    we,
  input  logic [addr_width-1:0]   waddr,
  input  systolic_pkg::lane_vec_t wdata,
  input  logic [addr_width-1:0]   raddr,
  output systolic_pkg::lane_vec_t rdata
);

  // one operand slice per address
  systolic_pkg::lane_vec_t mem [2**addr_width];

  // every slice starts as zero
  // the parked all-ones address then feeds zeros into the array
  initial begin
    for (int a = 0; a < 2**addr_width; a++) begin
      mem[a] <= '0;
    end
    rdata <= '0;
  end

  // write port for loading, registered read port for the DUT
  always @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
    // slice shows up one cycle after its address
    rdata <= mem[raddr];
  end

endmodule

// ==== tb_matmul.sv ====
module tb_matmul;

  localparam int addr_width = 7;
  localparam int n = systolic_pkg::array_size;
  localparam int w = systolic_pkg::data_width;

  // run cycle m = edges seen with start high
  // idle to run takes edge 1, so the count after edge m is m - 1
  localparam int first_addr_cycle = 2;
  // row r captured on the edge leaving count 11 + r, i.e. edge 13 + r
  localparam int first_c_cycle = 13;
  // done set on the edge leaving count 18
  localparam int done_cycle = 20;

  // six runs of about 30 cycles with loading, plus reset, with margin
  localparam int max_cycles = 400;

  localparam int small_mode = 0;
  localparam int large_mode = 1;
  localparam int mixed_mode = 2;

  logic                    clk;
  logic                    reset;
  logic                    start;
  logic                    done;
  logic [addr_width-1:0]   a_addr;
  logic [addr_width-1:0]   b_addr;
  systolic_pkg::lane_vec_t a_data;
  systolic_pkg::lane_vec_t b_data;
  systolic_pkg::lane_vec_t c_data;

  // loading side of both operand memories
  logic                    mem_we;
  logic [addr_width-1:0]   mem_waddr;
  systolic_pkg::lane_vec_t a_wdata;
  systolic_pkg::lane_vec_t b_wdata;

  int run_cycle = 0;
  int cycle_count = 0;

  // operands and reference product
  int unsigned a_mat [n][n];
  int unsigned b_mat [n][n];
  int unsigned c_exp [n][n];

  matmul_top #(
    .addr_width (addr_width)
  ) dut_i (
    .clk    (clk),
    .reset  (reset),
    .start  (start),
    .done   (done),
    .a_addr (a_addr),
    .b_addr (b_addr),
    .a_data (a_data),
    .b_data (b_data),
    .c_data (c_data)
  );

  tb_operand_mem #(
    .addr_width (addr_width)
  ) a_mem_i (
    .clk   (clk),
    .we    (mem_we),
    .waddr (mem_waddr),
    .wdata (a_wdata),
    .raddr (a_addr),
    .rdata (a_data)
  );

  tb_operand_mem #(
    .addr_width (addr_width)
  ) b_mem_i (
    .clk   (clk),
    .we    (mem_we),
    .waddr (mem_waddr),
    .wdata (b_wdata),
    .raddr (b_addr),
    .rdata (b_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // edges since start rose, back to zero while start is low
  always @(posedge clk) begin
    if (start) begin
      run_cycle <= run_cycle + 1;
    end else begin
      run_cycle <= 0;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("Timeout: the test did not finish within %0d cycles", max_cycles);
      $display("Test FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic stop_on_mismatch(string msg);
    $display("FAILED %0t: %s", $time, msg);
    $display("Test FAILED");
    $fatal(1, "wrong value from the DUT");
  endtask

  // slice addresses 0..3 on edges 2..5, parked at all ones otherwise
  function automatic logic [addr_width-1:0] expected_addr(int m);
    if (m >= first_addr_cycle && m < first_addr_cycle + n) begin
      return addr_width'(m - first_addr_cycle);
    end else begin
      return '1;
    end
  endfunction

  // lane r streams C[r][0..3] from edge 13 + r on, zero around it
  function automatic systolic_pkg::elem_t expected_lane(int r, int m);
    int idx;
    idx = m - first_c_cycle - r;
    if (idx >= 0 && idx < n) begin
      return systolic_pkg::elem_t'(c_exp[r][idx]);
    end else begin
      return '0;
    end
  endfunction

  function automatic int unsigned random_elem(int mode);
    int unsigned pick;
    pick = $urandom % 3;
    if (mode == small_mode || (mode == mixed_mode && pick == 1)) begin
      // four products of these stay below 16 bits
      return $urandom % 128;
    end else if (mode == large_mode || (mode == mixed_mode && pick == 2)) begin
      return 32'hff00 | ($urandom % 256);
    end else begin
      return 0;
    end
  endfunction

  // plain integer product, clamped to 16 bits
  task automatic prepare_operands(int mode);
    longint unsigned sum;
    for (int i = 0; i < n; i++) begin
      for (int j = 0; j < n; j++) begin
        a_mat[i][j] = random_elem(mode);
        b_mat[i][j] = random_elem(mode);
      end
    end
    for (int i = 0; i < n; i++) begin
      for (int j = 0; j < n; j++) begin
        sum = 0;
        for (int k = 0; k < n; k++) begin
          sum += longint'(a_mat[i][k]) * longint'(b_mat[k][j]);
        end
        c_exp[i][j] = (sum > 64'hffff) ? 32'hffff : int'(sum);
      end
    end
  endtask

  // slice k of A is column k, slice k of B is row k
  task automatic load_operands();
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      #10;
      mem_we = 1'b1;
      mem_waddr = addr_width'(k);
      for (int i = 0; i < n; i++) begin
        a_wdata[i*w +: w] = systolic_pkg::elem_t'(a_mat[i][k]);
        b_wdata[i*w +: w] = systolic_pkg::elem_t'(b_mat[k][i]);
      end
    end
    @(posedge clk);
    #10;
    mem_we = 1'b0;
  endtask

  // one four-phase transaction
  task automatic run_matmul(int mode);
    int hold;
    hold = $urandom % 4;
    prepare_operands(mode);
    load_operands();
    @(posedge clk);
    #10;
    start = 1'b1;
    do begin
      @(posedge clk);
      #10;
    end while (!done);
    // keep start up a little longer now and then
    repeat (hold) begin
      @(posedge clk);
      #10;
    end
    start = 1'b0;
    // done drops here
    @(posedge clk);
    #10;
  endtask

  initial begin
    void'($urandom(78));
    reset = 1'b1;
    start = 1'b0;
    mem_we = 1'b0;
    mem_waddr = '0;
    a_wdata = '0;
    b_wdata = '0;
    repeat (5) @(posedge clk);
    #10;
    reset = 1'b0;
    // a few idle cycles before the first start
    repeat (3) @(posedge clk);
    run_matmul(small_mode);
    run_matmul(small_mode);
    run_matmul(large_mode);
    run_matmul(mixed_mode);
    // small values right after saturated ones
    run_matmul(small_mode);
    run_matmul(mixed_mode);
    repeat (3) @(posedge clk);
    $display("Test OK");
    $finish;
  end

  // idle with start low, also right after reset
  idle_chk: assert property (@(posedge clk) disable iff (reset)
    (!start && !$past(start)) |-> (!done && a_addr == '1 && b_addr == '1))
    else stop_on_mismatch("done or an address not idle while start is low");

  a_addr_chk: assert property (@(posedge clk) disable iff (reset)
    start |-> (a_addr == expected_addr(run_cycle)))
    else stop_on_mismatch($sformatf("a_addr %0d in run cycle %0d",
                                    $sampled(a_addr), $sampled(run_cycle)));

  b_addr_chk: assert property (@(posedge clk) disable iff (reset)
    start |-> (b_addr == expected_addr(run_cycle)))
    else stop_on_mismatch($sformatf("b_addr %0d in run cycle %0d",
                                    $sampled(b_addr), $sampled(run_cycle)));

  done_chk: assert property (@(posedge clk) disable iff (reset)
    start |-> (done == (run_cycle >= done_cycle)))
    else stop_on_mismatch($sformatf("done %0b in run cycle %0d",
                                    $sampled(done), $sampled(run_cycle)));

  // done still up when start falls
  done_held_chk: assert property (@(posedge clk) disable iff (reset)
    $fell(start) |-> done)
    else stop_on_mismatch("done low when start fell");

  for (genvar r = 0; r < n; r++) begin : g_lane_chk
    c_lane_chk: assert property (@(posedge clk) disable iff (reset)
      start |-> (c_data[r*w +: w] == expected_lane(r, run_cycle)))
      else stop_on_mismatch($sformatf("c_data lane %0d in run cycle %0d, got %h, expected %h",
                                      r, $sampled(run_cycle), $sampled(c_data[r*w +: w]),
                                      expected_lane(r, $sampled(run_cycle))));
  end

endmodule

// ==== filelist.f ====
systolic_pkg.sv
mm_ctrl_if.sv
processing_element.sv
pe_array.sv
operand_skew.sv
result_drain.sv
mm_sequencer.sv
matmul_top.sv
tb_operand_mem.sv
tb_matmul.sv

// ==== Makefile ====
# Verilator build and run of the systolic matrix multiplier testbench
# the run target fails when the simulation ends with $fatal

TOP = tb_matmul

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f filelist.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
